// File: misc_pipe_defines.svh
`ifndef MISC_PIPE_DEFINES_SVH
`define MISC_PIPE_DEFINES_SVH

// ========================================
// datapath widths
// ========================================

// integer data path
`define MP_DATA_W 32

// virtual address, pc and branch target
`define MP_ADDR_W 32

// csr number field of csrrd/csrwr/csrxchg
`define MP_CSR_ADDR_W 14

// ========================================
// out-of-order bookkeeping
// ========================================

`define MP_PREG_W 6 // physical register index
`define MP_ROB_W 5  // rob slot index

// ========================================
// stable counter
// ========================================

// rdcntvl/rdcntvh read the low and high halves
`define MP_TIMER_W 64

`endif

// File: misc_pipe_pkg.sv
`default_nettype none

package misc_pipe_pkg;

  // ========================================
  // instruction class
  // ========================================

  typedef enum logic [1:0] {
    BR   = 2'd0, // conditional and unconditional branches
    PRIV = 2'd1, // csr access, ertn, idle
    MISC = 2'd2  // counter reads
  } instr_type_e;

  // ========================================
  // privileged ops
  // ========================================

  typedef enum logic [2:0] {
    CSR_READ  = 3'd0,
    CSR_WRITE = 3'd1,
    CSR_XCHG  = 3'd2, // masked write, old value returned
    ERTN      = 3'd3,
    IDLE      = 3'd4
  } priv_op_e;

  // ========================================
  // misc ops
  // ========================================

  typedef enum logic [1:0] {
    RDCNTVL = 2'd0, // counter bits 31:0
    RDCNTVH = 2'd1, // counter bits 63:32
    RDCNTID = 2'd2  // counter id
  } misc_op_e;

  // ========================================
  // branch ops
  // ========================================

  typedef enum logic [3:0] {
    BEQ  = 4'd0,
    BNE  = 4'd1,
    BLT  = 4'd2, // signed
    BGE  = 4'd3, // signed
    BLTU = 4'd4,
    BGEU = 4'd5,
    B    = 4'd6,
    BL   = 4'd7, // links pc + 4
    JIRL = 4'd8  // register indirect, links pc + 4
  } branch_op_e;

endpackage

`default_nettype wire

// File: misc_pipe_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module misc_pipe_ctrl (
  input  wire  clk,
  input  wire  rst_n,
  input  wire  flush_i,
  input  wire  exe_valid_i,
  input  wire  wb_ready_i,
  output logic ready_o,
  output logic s1_load_o,
  output logic s2_load_o,
  output logic s1_valid_o,
  output logic wb_valid_o
);

  logic s1_valid;
  logic s2_valid;
  logic s1_ready;
  logic s2_ready;

  // ========================================
  // ready chain
  // ========================================

  always_comb begin
    s2_ready = ~s2_valid | wb_ready_i; // empty or draining
    s1_ready = ~s1_valid | s2_ready;
    ready_o = s1_ready;

    s1_load_o = exe_valid_i & s1_ready; // only on a real transfer
    s2_load_o = s2_ready; // bubbles move too, record we is gated
  end

  // ========================================
  // occupancy
  // ========================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else if (flush_i) begin
      s1_valid <= 1'b0; // in-flight items dropped
      s2_valid <= 1'b0;
    end else begin
      if (s1_ready) begin
        s1_valid <= exe_valid_i;
      end
      if (s2_ready) begin
        s2_valid <= s1_valid;
      end
    end
  end

  assign s1_valid_o = s1_valid;
  assign wb_valid_o = s2_valid;

endmodule

`default_nettype wire

// File: misc_stage_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "misc_pipe_defines.svh"

module misc_stage_regs (
  input  wire                                 clk,
  input  wire                                 rst_n,
  input  wire                                 s1_load_i,
  input  wire                                 s2_load_i,
  input  wire                                 s1_valid_i,
  // exe fields
  input  misc_pipe_pkg::instr_type_e          exe_instr_type_i,
  input  misc_pipe_pkg::priv_op_e             exe_priv_op_i,
  input  misc_pipe_pkg::misc_op_e             exe_misc_op_i,
  input  misc_pipe_pkg::branch_op_e           exe_branch_op_i,
  input  wire        [`MP_DATA_W-1:0]         exe_src0_i,
  input  wire        [`MP_DATA_W-1:0]         exe_src1_i,
  input  wire        [`MP_DATA_W-1:0]         exe_imm_i,
  input  wire        [`MP_ADDR_W-1:0]         exe_pc_i,
  input  wire        [`MP_ADDR_W-1:0]         exe_npc_i,
  input  wire                                 exe_pdest_valid_i,
  input  wire        [`MP_PREG_W-1:0]         exe_pdest_i,
  input  wire        [`MP_ROB_W-1:0]          exe_rob_idx_i,
  // side inputs, same cycle as exe
  input  wire        [`MP_DATA_W-1:0]         csr_rdata_i,
  input  wire        [`MP_TIMER_W-1:0]        timer_64_i,
  input  wire        [`MP_DATA_W-1:0]         timer_id_i,
  // stage-2 inputs from the units
  input  wire        [`MP_DATA_W-1:0]         wdata_i,
  input  wire                                 csr_we_i,
  input  wire        [`MP_CSR_ADDR_W-1:0]     csr_waddr_i,
  input  wire        [`MP_DATA_W-1:0]         csr_wdata_i,
  input  wire                                 ertn_i,
  input  wire                                 idle_i,
  input  wire                                 br_taken_i,
  input  wire                                 br_redirect_i,
  input  wire        [`MP_ADDR_W-1:0]         br_target_i,
  // stage-1 copy
  output misc_pipe_pkg::instr_type_e          s1_instr_type_o,
  output misc_pipe_pkg::priv_op_e             s1_priv_op_o,
  output misc_pipe_pkg::misc_op_e             s1_misc_op_o,
  output misc_pipe_pkg::branch_op_e           s1_branch_op_o,
  output logic       [`MP_DATA_W-1:0]         s1_src0_o,
  output logic       [`MP_DATA_W-1:0]         s1_src1_o,
  output logic       [`MP_DATA_W-1:0]         s1_imm_o,
  output logic       [`MP_ADDR_W-1:0]         s1_pc_o,
  output logic       [`MP_ADDR_W-1:0]         s1_npc_o,
  output logic       [`MP_DATA_W-1:0]         s1_csr_rdata_o,
  output logic       [`MP_TIMER_W-1:0]        s1_timer_64_o,
  output logic       [`MP_DATA_W-1:0]         s1_timer_id_o,
  // write-back record
  output logic                                wb_we_o,
  output logic       [`MP_DATA_W-1:0]         wb_wdata_o,
  output logic       [`MP_PREG_W-1:0]         wb_pdest_o,
  output logic       [`MP_ROB_W-1:0]          wb_rob_idx_o,
  output logic                                wb_csr_we_o,
  output logic       [`MP_CSR_ADDR_W-1:0]     wb_csr_waddr_o,
  output logic       [`MP_DATA_W-1:0]         wb_csr_wdata_o,
  output logic                                wb_br_taken_o,
  output logic                                wb_br_redirect_o,
  output logic       [`MP_ADDR_W-1:0]         wb_br_target_o,
  output logic                                wb_ertn_o,
  output logic                                wb_idle_o
);

  logic                  s1_pdest_valid;
  logic [`MP_PREG_W-1:0] s1_pdest;
  logic [`MP_ROB_W-1:0]  s1_rob_idx;

  // ========================================
  // stage 1
  // ========================================

  always_ff @(posedge clk) begin
    if (s1_load_i) begin
      s1_instr_type_o <= exe_instr_type_i;
      s1_priv_op_o <= exe_priv_op_i;
      s1_misc_op_o <= exe_misc_op_i;
      s1_branch_op_o <= exe_branch_op_i;
      s1_src0_o <= exe_src0_i;
      s1_src1_o <= exe_src1_i;
      s1_imm_o <= exe_imm_i;
      s1_pc_o <= exe_pc_i;
      s1_npc_o <= exe_npc_i;
      s1_pdest_valid <= exe_pdest_valid_i;
      s1_pdest <= exe_pdest_i;
      s1_rob_idx <= exe_rob_idx_i;
      s1_csr_rdata_o <= csr_rdata_i; // sampled with exe
      s1_timer_64_o <= timer_64_i;
      s1_timer_id_o <= timer_id_i;
    end
  end

  // ========================================
  // stage 2
  // ========================================

  // strobes seen by commit
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_we_o <= 1'b0;
      wb_csr_we_o <= 1'b0;
      wb_br_taken_o <= 1'b0;
      wb_br_redirect_o <= 1'b0;
      wb_ertn_o <= 1'b0;
      wb_idle_o <= 1'b0;
    end else if (s2_load_i) begin
      wb_we_o <= s1_pdest_valid & s1_valid_i; // bubble never writes
      wb_csr_we_o <= csr_we_i;
      wb_br_taken_o <= br_taken_i;
      wb_br_redirect_o <= br_redirect_i;
      wb_ertn_o <= ertn_i;
      wb_idle_o <= idle_i;
    end
  end

  // payload
  always_ff @(posedge clk) begin
    if (s2_load_i) begin
      wb_wdata_o <= wdata_i;
      wb_pdest_o <= s1_pdest;
      wb_rob_idx_o <= s1_rob_idx;
      wb_csr_waddr_o <= csr_waddr_i;
      wb_csr_wdata_o <= csr_wdata_i;
      wb_br_target_o <= br_target_i;
    end
  end

endmodule

`default_nettype wire

// File: branch_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "misc_pipe_defines.svh"

module branch_unit (
  input  wire                       valid_i,
  input  misc_pipe_pkg::branch_op_e branch_op_i,
  input  wire  [`MP_ADDR_W-1:0]     pc_i,
  input  wire  [`MP_ADDR_W-1:0]     npc_i,  // predicted next pc
  input  wire  [`MP_DATA_W-1:0]     imm_i,
  input  wire  [`MP_DATA_W-1:0]     src0_i,
  input  wire  [`MP_DATA_W-1:0]     src1_i,
  output logic                      taken_o,
  output logic                      redirect_o,
  output logic [`MP_ADDR_W-1:0]     target_o
);

  logic                  eq;
  logic                  lt_s;
  logic                  lt_u;
  logic [`MP_ADDR_W-1:0] next_pc;

  // ========================================
  // condition
  // ========================================

  always_comb begin
    eq = src0_i == src1_i;
    lt_s = $signed(src0_i) < $signed(src1_i);
    lt_u = src0_i < src1_i;

    case (branch_op_i)
      misc_pipe_pkg::BEQ:  taken_o = eq;
      misc_pipe_pkg::BNE:  taken_o = ~eq;
      misc_pipe_pkg::BLT:  taken_o = lt_s;
      misc_pipe_pkg::BGE:  taken_o = ~lt_s;
      misc_pipe_pkg::BLTU: taken_o = lt_u;
      misc_pipe_pkg::BGEU: taken_o = ~lt_u;
      misc_pipe_pkg::B,
      misc_pipe_pkg::BL,
      misc_pipe_pkg::JIRL: taken_o = 1'b1; // unconditional
      default:             taken_o = 1'b0;
    endcase
  end

  // ========================================
  // target and redirect
  // ========================================

  always_comb begin
    if (branch_op_i == misc_pipe_pkg::JIRL) begin
      target_o = src0_i + imm_i; // register base
    end else begin
      target_o = pc_i + imm_i;
    end

    next_pc = taken_o ? target_o : pc_i + `MP_ADDR_W'd4;

    // frontend guessed wrong
    redirect_o = valid_i & (next_pc != npc_i);
  end

endmodule

`default_nettype wire

// File: misc_result_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "misc_pipe_defines.svh"

module misc_result_unit (
  input  misc_pipe_pkg::instr_type_e  instr_type_i,
  input  misc_pipe_pkg::priv_op_e     priv_op_i,
  input  misc_pipe_pkg::misc_op_e     misc_op_i,
  input  wire  [`MP_ADDR_W-1:0]       pc_i,
  input  wire  [`MP_DATA_W-1:0]       src0_i,
  input  wire  [`MP_DATA_W-1:0]       src1_i,   // xchg mask
  input  wire  [`MP_DATA_W-1:0]       imm_i,
  input  wire  [`MP_DATA_W-1:0]       csr_rdata_i,
  input  wire  [`MP_TIMER_W-1:0]      timer_64_i,
  input  wire  [`MP_DATA_W-1:0]       timer_id_i,
  output logic [`MP_DATA_W-1:0]       wdata_o,
  output logic                        csr_we_o,
  output logic [`MP_CSR_ADDR_W-1:0]   csr_waddr_o,
  output logic [`MP_DATA_W-1:0]       csr_wdata_o,
  output logic                        ertn_o,
  output logic                        idle_o
);

  logic is_priv;

  // ========================================
  // write-back data
  // ========================================

  always_comb begin
    wdata_o = '0;
    case (instr_type_i)
      misc_pipe_pkg::BR:   wdata_o = pc_i + `MP_ADDR_W'd4; // link value
      misc_pipe_pkg::PRIV: wdata_o = csr_rdata_i; // old csr value
      misc_pipe_pkg::MISC: begin
        case (misc_op_i)
          misc_pipe_pkg::RDCNTVL: wdata_o = timer_64_i[`MP_DATA_W-1:0];
          misc_pipe_pkg::RDCNTVH: wdata_o = timer_64_i[`MP_TIMER_W-1:`MP_DATA_W];
          misc_pipe_pkg::RDCNTID: wdata_o = timer_id_i;
          default:                wdata_o = '0;
        endcase
      end
      default: wdata_o = '0;
    endcase
  end

  // ========================================
  // csr write and privileged strobes
  // ========================================

  always_comb begin
    is_priv = instr_type_i == misc_pipe_pkg::PRIV;

    csr_we_o = is_priv & (priv_op_i == misc_pipe_pkg::CSR_WRITE |
                          priv_op_i == misc_pipe_pkg::CSR_XCHG);
    csr_waddr_o = imm_i[`MP_CSR_ADDR_W-1:0];

    if (priv_op_i == misc_pipe_pkg::CSR_XCHG) begin
      csr_wdata_o = (src0_i & src1_i) | (csr_rdata_i & ~src1_i); // masked merge
    end else begin
      csr_wdata_o = src0_i;
    end

    ertn_o = is_priv & (priv_op_i == misc_pipe_pkg::ERTN);
    idle_o = is_priv & (priv_op_i == misc_pipe_pkg::IDLE);
  end

endmodule

`default_nettype wire

// File: misc_pipe_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "misc_pipe_defines.svh"

module misc_pipe_top (
  input  wire                             clk,
  input  wire                             rst_n,
  input  wire                             flush_i,
  // exe side
  input  wire                             exe_valid_i,
  output logic                            ready_o,
  input  misc_pipe_pkg::instr_type_e      exe_instr_type_i,
  input  misc_pipe_pkg::priv_op_e         exe_priv_op_i,
  input  misc_pipe_pkg::misc_op_e         exe_misc_op_i,
  input  misc_pipe_pkg::branch_op_e       exe_branch_op_i,
  input  wire  [`MP_DATA_W-1:0]           exe_src0_i,
  input  wire  [`MP_DATA_W-1:0]           exe_src1_i,
  input  wire  [`MP_DATA_W-1:0]           exe_imm_i,
  input  wire  [`MP_ADDR_W-1:0]           exe_pc_i,
  input  wire  [`MP_ADDR_W-1:0]           exe_npc_i,
  input  wire                             exe_pdest_valid_i,
  input  wire  [`MP_PREG_W-1:0]           exe_pdest_i,
  input  wire  [`MP_ROB_W-1:0]            exe_rob_idx_i,
  input  wire  [`MP_DATA_W-1:0]           csr_rdata_i,
  input  wire  [`MP_TIMER_W-1:0]          timer_64_i,
  input  wire  [`MP_DATA_W-1:0]           timer_id_i,
  // commit side
  output logic                            wb_valid_o,
  input  wire                             wb_ready_i,
  output logic                            wb_we_o,
  output logic [`MP_DATA_W-1:0]           wb_wdata_o,
  output logic [`MP_PREG_W-1:0]           wb_pdest_o,
  output logic [`MP_ROB_W-1:0]            wb_rob_idx_o,
  output logic                            wb_csr_we_o,
  output logic [`MP_CSR_ADDR_W-1:0]       wb_csr_waddr_o,
  output logic [`MP_DATA_W-1:0]           wb_csr_wdata_o,
  output logic                            wb_br_taken_o,
  output logic                            wb_br_redirect_o,
  output logic [`MP_ADDR_W-1:0]           wb_br_target_o,
  output logic                            wb_ertn_o,
  output logic                            wb_idle_o
);

  // ========================================
  // stage-1 view
  // ========================================

  logic                       s1_load;
  logic                       s2_load;
  logic                       s1_valid;
  misc_pipe_pkg::instr_type_e s1_instr_type;
  misc_pipe_pkg::priv_op_e    s1_priv_op;
  misc_pipe_pkg::misc_op_e    s1_misc_op;
  misc_pipe_pkg::branch_op_e  s1_branch_op;
  logic [`MP_DATA_W-1:0]      s1_src0;
  logic [`MP_DATA_W-1:0]      s1_src1;
  logic [`MP_DATA_W-1:0]      s1_imm;
  logic [`MP_ADDR_W-1:0]      s1_pc;
  logic [`MP_ADDR_W-1:0]      s1_npc;
  logic [`MP_DATA_W-1:0]      s1_csr_rdata;
  logic [`MP_TIMER_W-1:0]     s1_timer_64;
  logic [`MP_DATA_W-1:0]      s1_timer_id;

  // unit results into stage 2
  logic                       br_valid;
  logic                       br_taken;
  logic                       br_redirect;
  logic [`MP_ADDR_W-1:0]      br_target;
  logic [`MP_DATA_W-1:0]      wdata;
  logic                       csr_we;
  logic [`MP_CSR_ADDR_W-1:0]  csr_waddr;
  logic [`MP_DATA_W-1:0]      csr_wdata;
  logic                       ertn;
  logic                       idle;

  assign br_valid = s1_valid & (s1_instr_type == misc_pipe_pkg::BR); // only real branches

  misc_pipe_ctrl misc_pipe_ctrl_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (flush_i),
    .exe_valid_i (exe_valid_i),
    .wb_ready_i  (wb_ready_i),
    .ready_o     (ready_o),
    .s1_load_o   (s1_load),
    .s2_load_o   (s2_load),
    .s1_valid_o  (s1_valid),
    .wb_valid_o  (wb_valid_o)
  );

  misc_stage_regs misc_stage_regs_inst (
    .clk               (clk),
    .rst_n             (rst_n),
    .s1_load_i         (s1_load),
    .s2_load_i         (s2_load),
    .s1_valid_i        (s1_valid),
    .exe_instr_type_i  (exe_instr_type_i),
    .exe_priv_op_i     (exe_priv_op_i),
    .exe_misc_op_i     (exe_misc_op_i),
    .exe_branch_op_i   (exe_branch_op_i),
    .exe_src0_i        (exe_src0_i),
    .exe_src1_i        (exe_src1_i),
    .exe_imm_i         (exe_imm_i),
    .exe_pc_i          (exe_pc_i),
    .exe_npc_i         (exe_npc_i),
    .exe_pdest_valid_i (exe_pdest_valid_i),
    .exe_pdest_i       (exe_pdest_i),
    .exe_rob_idx_i     (exe_rob_idx_i),
    .csr_rdata_i       (csr_rdata_i),
    .timer_64_i        (timer_64_i),
    .timer_id_i        (timer_id_i),
    .wdata_i           (wdata),
    .csr_we_i          (csr_we),
    .csr_waddr_i       (csr_waddr),
    .csr_wdata_i       (csr_wdata),
    .ertn_i            (ertn),
    .idle_i            (idle),
    .br_taken_i        (br_taken),
    .br_redirect_i     (br_redirect),
    .br_target_i       (br_target),
    .s1_instr_type_o   (s1_instr_type),
    .s1_priv_op_o      (s1_priv_op),
    .s1_misc_op_o      (s1_misc_op),
    .s1_branch_op_o    (s1_branch_op),
    .s1_src0_o         (s1_src0),
    .s1_src1_o         (s1_src1),
    .s1_imm_o          (s1_imm),
    .s1_pc_o           (s1_pc),
    .s1_npc_o          (s1_npc),
    .s1_csr_rdata_o    (s1_csr_rdata),
    .s1_timer_64_o     (s1_timer_64),
    .s1_timer_id_o     (s1_timer_id),
    .wb_we_o           (wb_we_o),
    .wb_wdata_o        (wb_wdata_o),
    .wb_pdest_o        (wb_pdest_o),
    .wb_rob_idx_o      (wb_rob_idx_o),
    .wb_csr_we_o       (wb_csr_we_o),
    .wb_csr_waddr_o    (wb_csr_waddr_o),
    .wb_csr_wdata_o    (wb_csr_wdata_o),
    .wb_br_taken_o     (wb_br_taken_o),
    .wb_br_redirect_o  (wb_br_redirect_o),
    .wb_br_target_o    (wb_br_target_o),
    .wb_ertn_o         (wb_ertn_o),
    .wb_idle_o         (wb_idle_o)
  );

  branch_unit branch_unit_inst (
    .valid_i     (br_valid),
    .branch_op_i (s1_branch_op),
    .pc_i        (s1_pc),
    .npc_i       (s1_npc),
    .imm_i       (s1_imm),
    .src0_i      (s1_src0),
    .src1_i      (s1_src1),
    .taken_o     (br_taken),
    .redirect_o  (br_redirect),
    .target_o    (br_target)
  );

  misc_result_unit misc_result_unit_inst (
    .instr_type_i (s1_instr_type),
    .priv_op_i    (s1_priv_op),
    .misc_op_i    (s1_misc_op),
    .pc_i         (s1_pc),
    .src0_i       (s1_src0),
    .src1_i       (s1_src1),
    .imm_i        (s1_imm),
    .csr_rdata_i  (s1_csr_rdata),
    .timer_64_i   (s1_timer_64),
    .timer_id_i   (s1_timer_id),
    .wdata_o      (wdata),
    .csr_we_o     (csr_we),
    .csr_waddr_o  (csr_waddr),
    .csr_wdata_o  (csr_wdata),
    .ertn_o       (ertn),
    .idle_o       (idle)
  );

endmodule

`default_nettype wire

// File: tb_misc_pipe.sv
`timescale 1ns/1ns
`default_nettype none

`include "misc_pipe_defines.svh"

module tb_misc_pipe;

  localparam int NUM_CASES = 17;
  localparam int NUM_FIELDS = 25; // 15 inputs, 10 expected
  localparam int FLUSH_ITEMS = 2; // fills both stages
  localparam int POST_FLUSH_FIRST = 9;
  localparam int NUM_ISSUES = 2 * NUM_CASES + FLUSH_ITEMS + (NUM_CASES - POST_FLUSH_FIRST);
  localparam int WATCHDOG_CYCLES = NUM_ISSUES * 20 + 200;
  localparam int WB_REC_W = 2 * `MP_DATA_W + `MP_ADDR_W + `MP_PREG_W + `MP_ROB_W +
                            `MP_CSR_ADDR_W + 6;

  logic                       clk;
  logic                       rst_n;
  logic                       flush_i;
  logic                       exe_valid_i;
  logic                       ready_o;
  misc_pipe_pkg::instr_type_e exe_instr_type_i;
  misc_pipe_pkg::priv_op_e    exe_priv_op_i;
  misc_pipe_pkg::misc_op_e    exe_misc_op_i;
  misc_pipe_pkg::branch_op_e  exe_branch_op_i;
  logic [`MP_DATA_W-1:0]      exe_src0_i;
  logic [`MP_DATA_W-1:0]      exe_src1_i;
  logic [`MP_DATA_W-1:0]      exe_imm_i;
  logic [`MP_ADDR_W-1:0]      exe_pc_i;
  logic [`MP_ADDR_W-1:0]      exe_npc_i;
  logic                       exe_pdest_valid_i;
  logic [`MP_PREG_W-1:0]      exe_pdest_i;
  logic [`MP_ROB_W-1:0]       exe_rob_idx_i;
  logic [`MP_DATA_W-1:0]      csr_rdata_i;
  logic [`MP_TIMER_W-1:0]     timer_64_i;
  logic [`MP_DATA_W-1:0]      timer_id_i;
  logic                       wb_valid_o;
  logic                       wb_ready_i;
  logic                       wb_we_o;
  logic [`MP_DATA_W-1:0]      wb_wdata_o;
  logic [`MP_PREG_W-1:0]      wb_pdest_o;
  logic [`MP_ROB_W-1:0]       wb_rob_idx_o;
  logic                       wb_csr_we_o;
  logic [`MP_CSR_ADDR_W-1:0]  wb_csr_waddr_o;
  logic [`MP_DATA_W-1:0]      wb_csr_wdata_o;
  logic                       wb_br_taken_o;
  logic                       wb_br_redirect_o;
  logic [`MP_ADDR_W-1:0]      wb_br_target_o;
  logic                       wb_ertn_o;
  logic                       wb_idle_o;

  logic [`MP_TIMER_W-1:0] case_mem [0:NUM_CASES*NUM_FIELDS-1];
  int                     case_q[$];  // outstanding case index, issue order
  int                     phase_q[$];
  int                     issue_q[$]; // cycle of the transfer edge
  int                     cycle;
  int                     value_errs;
  int                     proto_errs;
  logic [1:0]             ready_mode; // 0 high, 1 random, 2 low
  logic                   held;
  logic [WB_REC_W-1:0]    held_rec;

  misc_pipe_top misc_pipe_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  // commit side readiness
  initial begin
    int rnd;
    rnd = $urandom(41);
    forever begin
      @(posedge clk);
      case (ready_mode)
        2'd0: wb_ready_i <= 1'b1;
        2'd1: wb_ready_i <= ($urandom % 2) == 0;
        default: wb_ready_i <= 1'b0;
      endcase
    end
  end

  // ========================================
  // compare tasks
  // ========================================

  task automatic check_data(input string name, input string field,
                            input logic [`MP_DATA_W-1:0] exp, input logic [`MP_DATA_W-1:0] act);
    if (act !== exp) begin
      value_errs++;
      $display("[FAIL] %s %s: expected %h, actual %h", name, field, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input string field,
                            input logic exp, input logic act);
    if (act !== exp) begin
      value_errs++;
      $display("[FAIL] %s %s: expected %b, actual %b", name, field, exp, act);
    end
  endtask

  task automatic check_target(input string name, input string field,
                              input logic [`MP_ADDR_W-1:0] exp, input logic [`MP_ADDR_W-1:0] act);
    if (act !== exp) begin
      value_errs++;
      $display("[FAIL] %s %s: expected %h, actual %h", name, field, exp, act);
    end
  endtask

  function automatic string phase_label(input int phase);
    case (phase)
      0: return "latency";
      1: return "backpressure";
      default: return "flush";
    endcase
  endfunction

  function automatic logic [WB_REC_W-1:0] wb_snapshot();
    return {wb_we_o, wb_wdata_o, wb_pdest_o, wb_rob_idx_o, wb_csr_we_o, wb_csr_waddr_o,
            wb_csr_wdata_o, wb_br_taken_o, wb_br_redirect_o, wb_br_target_o,
            wb_ertn_o, wb_idle_o};
  endfunction

  task automatic compare_record(input int idx, input int phase, input int issue_cyc);
    int    base;
    int    e;
    string name;
    base = idx * NUM_FIELDS;
    e = base + 15; // first expected field
    name = $sformatf("%s case %0d", phase_label(phase), idx);
    // ready held high in these phases
    if (phase != 1 && cycle - issue_cyc != 2) begin
      proto_errs++;
      $display("%s reached write-back %0d cycles after transfer instead of 2",
               name, cycle - issue_cyc);
    end
    check_data(name, "rob_idx", `MP_DATA_W'(case_mem[base+11]), `MP_DATA_W'(wb_rob_idx_o));
    check_flag(name, "we", case_mem[e][0], wb_we_o);
    if (case_mem[e][0]) begin
      check_data(name, "wdata", case_mem[e+1][`MP_DATA_W-1:0], wb_wdata_o);
      check_data(name, "pdest", `MP_DATA_W'(case_mem[base+10]), `MP_DATA_W'(wb_pdest_o));
    end
    check_flag(name, "csr_we", case_mem[e+2][0], wb_csr_we_o);
    if (case_mem[e+2][0]) begin
      check_data(name, "csr_waddr", `MP_DATA_W'(case_mem[e+3]), `MP_DATA_W'(wb_csr_waddr_o));
      check_data(name, "csr_wdata", case_mem[e+4][`MP_DATA_W-1:0], wb_csr_wdata_o);
    end
    if (case_mem[base][1:0] == misc_pipe_pkg::BR) begin
      check_flag(name, "taken", case_mem[e+5][0], wb_br_taken_o);
      check_target(name, "target", case_mem[e+7][`MP_ADDR_W-1:0], wb_br_target_o);
    end
    check_flag(name, "redirect", case_mem[e+6][0], wb_br_redirect_o);
    check_flag(name, "ertn", case_mem[e+8][0], wb_ertn_o);
    check_flag(name, "idle", case_mem[e+9][0], wb_idle_o);
  endtask

  // ========================================
  // monitor
  // ========================================

  always @(posedge clk) begin
    if (rst_n && wb_valid_o) begin
      if (held && wb_snapshot() !== held_rec) begin
        proto_errs++;
        $display("wb outputs changed while the record was held by wb_ready_i low");
      end
      if (wb_ready_i) begin
        if (case_q.size() == 0) begin
          proto_errs++;
          $display("wb transfer at cycle %0d with no instruction outstanding", cycle);
        end else begin
          compare_record(case_q.pop_front(), phase_q.pop_front(), issue_q.pop_front());
        end
      end
    end
    held = rst_n && wb_valid_o && !wb_ready_i;
    held_rec = wb_snapshot();
  end

  // ========================================
  // driver
  // ========================================

  // called on a rising edge, returns on the transfer edge
  task automatic issue_case(input int idx, input int phase);
    int base;
    base = idx * NUM_FIELDS;
    exe_valid_i <= 1'b1;
    exe_instr_type_i <= misc_pipe_pkg::instr_type_e'(case_mem[base][1:0]);
    exe_priv_op_i <= misc_pipe_pkg::priv_op_e'(case_mem[base+1][2:0]);
    exe_misc_op_i <= misc_pipe_pkg::misc_op_e'(case_mem[base+2][1:0]);
    exe_branch_op_i <= misc_pipe_pkg::branch_op_e'(case_mem[base+3][3:0]);
    exe_src0_i <= case_mem[base+4][`MP_DATA_W-1:0];
    exe_src1_i <= case_mem[base+5][`MP_DATA_W-1:0];
    exe_imm_i <= case_mem[base+6][`MP_DATA_W-1:0];
    exe_pc_i <= case_mem[base+7][`MP_ADDR_W-1:0];
    exe_npc_i <= case_mem[base+8][`MP_ADDR_W-1:0];
    exe_pdest_valid_i <= case_mem[base+9][0];
    exe_pdest_i <= case_mem[base+10][`MP_PREG_W-1:0];
    exe_rob_idx_i <= case_mem[base+11][`MP_ROB_W-1:0];
    csr_rdata_i <= case_mem[base+12][`MP_DATA_W-1:0];
    timer_64_i <= case_mem[base+13];
    timer_id_i <= case_mem[base+14][`MP_DATA_W-1:0];
    @(posedge clk);
    while (!ready_o) @(posedge clk);
    case_q.push_back(idx);
    phase_q.push_back(phase);
    issue_q.push_back(cycle);
  endtask

  task automatic run_cases(input int first, input int last, input int phase);
    for (int i = first; i <= last; i++) begin
      issue_case(i, phase); // back to back
    end
    exe_valid_i <= 1'b0;
  endtask

  task automatic drain_pipe();
    int waited;
    waited = 0;
    while (case_q.size() != 0 && waited < 100) begin
      @(posedge clk);
      waited++;
    end
    if (case_q.size() != 0) begin
      proto_errs++;
      $display("%0d issued cases never reached write-back", case_q.size());
    end
  endtask

  // ========================================
  // main sequence
  // ========================================

  initial begin
    cycle = 0;
    value_errs = 0;
    proto_errs = 0;
    ready_mode = 2'd0;
    held = 1'b0;
    held_rec = '0;
    rst_n = 1'b0;
    flush_i = 1'b0;
    exe_valid_i = 1'b0;
    exe_instr_type_i = misc_pipe_pkg::BR;
    exe_priv_op_i = misc_pipe_pkg::CSR_READ;
    exe_misc_op_i = misc_pipe_pkg::RDCNTVL;
    exe_branch_op_i = misc_pipe_pkg::BEQ;
    exe_src0_i = '0;
    exe_src1_i = '0;
    exe_imm_i = '0;
    exe_pc_i = '0;
    exe_npc_i = '0;
    exe_pdest_valid_i = 1'b0;
    exe_pdest_i = '0;
    exe_rob_idx_i = '0;
    csr_rdata_i = '0;
    timer_64_i = '0;
    timer_id_i = '0;
    wb_ready_i = 1'b1;
    $readmemh("misc_pipe_cases.txt", case_mem);
    if ($isunknown(case_mem[NUM_CASES*NUM_FIELDS-1])) begin
      proto_errs++;
      $display("case file is missing or shorter than %0d cases", NUM_CASES);
    end

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    if (!ready_o) begin
      proto_errs++;
      $display("ready_o is low after reset");
    end

    run_cases(0, NUM_CASES - 1, 0); // ready held high
    drain_pipe();

    ready_mode <= 2'd1;
    run_cases(0, NUM_CASES - 1, 1);
    drain_pipe();

    // stall commit so both stages fill, then flush them
    ready_mode <= 2'd2;
    repeat (2) @(posedge clk);
    run_cases(0, FLUSH_ITEMS - 1, 2);
    flush_i <= 1'b1;
    @(posedge clk);
    flush_i <= 1'b0;
    ready_mode <= 2'd0;
    case_q.delete();
    phase_q.delete();
    issue_q.delete();
    repeat (4) begin
      @(posedge clk);
      if (wb_valid_o) begin
        proto_errs++;
        $display("wb_valid_o high after flush with nothing issued");
      end
    end
    run_cases(POST_FLUSH_FIRST, NUM_CASES - 1, 2);
    drain_pipe();

    $display("errors: %0d wrong values, %0d protocol errors", value_errs, proto_errs);
    if (value_errs == 0 && proto_errs == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout after %0d cycles, pipe stopped making progress", WATCHDOG_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: misc_pipe_cases.txt
// two lines per case, inputs first, then expected results
// in:  type priv misc bop src0 src1 imm pc npc pdest_valid pdest rob csr_rdata timer_64 timer_id
// exp: we wdata csr_we csr_waddr csr_wdata taken redirect target ertn idle
0 0 0 0 00000010 00000010 00000040 1c000000 1c000004 0 00 00 00000000 0 00000000
0 1c000004 0 0000 00000000 1 1 1c000040 0 0
0 0 0 1 00000010 00000010 00000020 1c000010 1c000014 0 00 01 00000000 0 00000000
0 1c000014 0 0000 00000000 0 0 1c000030 0 0
0 0 0 2 ffffffff 00000001 fffffff0 1c000100 1c0000f0 0 00 02 00000000 0 00000000
0 1c000104 0 0000 00000000 1 0 1c0000f0 0 0
0 0 0 3 ffffffff 00000001 00000008 1c000200 1c000208 0 00 03 00000000 0 00000000
0 1c000204 0 0000 00000000 0 1 1c000208 0 0
0 0 0 4 ffffffff 00000001 00000010 1c000300 1c000304 0 00 04 00000000 0 00000000
0 1c000304 0 0000 00000000 0 0 1c000310 0 0
0 0 0 5 ffffffff 00000001 00000100 1c000400 1c000404 0 00 05 00000000 0 00000000
0 1c000404 0 0000 00000000 1 1 1c000500 0 0
0 0 0 6 00000000 00000000 00001000 1c000500 1c001500 0 00 06 00000000 0 00000000
0 1c000504 0 0000 00000000 1 0 1c001500 0 0
0 0 0 7 00000000 00000000 fffff000 1c002000 1c002004 1 01 07 00000000 0 00000000
1 1c002004 0 0000 00000000 1 1 1c001000 0 0
0 0 0 8 1c010000 00000000 0000000c 1c003000 1c01000c 1 02 08 00000000 0 00000000
1 1c003004 0 0000 00000000 1 0 1c01000c 0 0
1 0 0 0 00000000 00000000 00000005 1c004000 1c004004 1 03 09 0000000b 0 00000000
1 0000000b 0 0005 00000000 0 0 00000000 0 0
1 1 0 0 deadbeef 00000000 0000c006 1c004004 1c004008 1 04 0a 12345678 0 00000000
1 12345678 1 0006 deadbeef 0 0 00000000 0 0
1 2 0 0 aaaaaaaa 0000ffff 00000100 1c004008 1c00400c 1 05 0b 12345678 0 00000000
1 12345678 1 0100 1234aaaa 0 0 00000000 0 0
2 0 0 0 00000000 00000000 00000000 1c00400c 1c004010 1 06 0c 00000000 0123456789abcdef 00000000
1 89abcdef 0 0000 00000000 0 0 00000000 0 0
2 0 1 0 00000000 00000000 00000000 1c004010 1c004014 1 07 0d 00000000 0123456789abcdef 00000000
1 01234567 0 0000 00000000 0 0 00000000 0 0
2 0 2 0 00000000 00000000 00000000 1c004014 1c004018 1 08 0e 00000000 0123456789abcdef 00000003
1 00000003 0 0000 00000000 0 0 00000000 0 0
1 3 0 0 00000000 00000000 00000000 1c004018 1c00401c 0 00 0f 00000000 0 00000000
0 00000000 0 0000 00000000 0 0 00000000 1 0
1 4 0 0 00000000 00000000 00000000 1c00401c 1c004020 0 00 10 00000000 0 00000000
0 00000000 0 0000 00000000 0 0 00000000 0 1

// File: misc_pipe.f
+incdir+.
misc_pipe_pkg.sv
misc_pipe_ctrl.sv
misc_stage_regs.sv
branch_unit.sv
misc_result_unit.sv
misc_pipe_top.sv
tb_misc_pipe.sv

// File: Bender.yml
package:
  name: misc_pipe

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - misc_pipe_pkg.sv
      - misc_pipe_ctrl.sv
      - misc_stage_regs.sv
      - branch_unit.sv
      - misc_result_unit.sv
      - misc_pipe_top.sv

  - target: simulation
    include_dirs:
      - .
    files:
      - tb_misc_pipe.sv
